/* rv_decoder.f */
+incdir+verilog
+incdir+tb
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_imm_gen.sv
verilog/rv_op_decode.sv
verilog/rv_decoder.sv
tb/tb_rv_decoder.sv

/* tb/rv_decoder_ref.svh */
`ifndef RV_DECODER_REF_SVH
`define RV_DECODER_REF_SVH

// ############################################################################
// expected decode of one instruction word, straight from the RV64I tables.
// flag order is {is_unsigned, is_word, is_imm, is_load, is_store, need_to_wb}.
// ############################################################################

function automatic void ref_decode(
    input  logic [31:0] w,
    output alu_op_e     alu,
    output cx_op_e      cx,
    output ls_size_e    ls,
    output logic [63:0] im,
    output logic [5:0]  fl
);
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic               ok;
    logic               reg_form;
    logic               word_form;
    ls_size_e           sz;
    imm_fmt_e           fmt;
    logic signed [63:0] s;

    f3  = w[14:12];
    f7  = w[31:25];
    ok  = 1'b1;
    alu = ALU_NONE;
    cx  = CX_NONE;
    ls  = LS_NONE;
    fl  = 6'b000000;
    fmt = IMM_NONE;
    case (f3[1:0])
        2'b00:   sz = LS_B;
        2'b01:   sz = LS_H;
        2'b10:   sz = LS_W;
        default: sz = LS_D;
    endcase

    case (w[6:0])
        LUI: begin
            fmt = IMM_U;
            alu = ALU_LUI;
            fl  = 6'b000001;
        end
        AUIPC: begin
            fmt = IMM_U;
            alu = ALU_AUIPC;
            fl  = 6'b000001;
        end
        JAL: begin
            fmt = IMM_J;
            cx  = CX_JAL;
            fl  = 6'b000001;
        end
        JALR: begin
            fmt = IMM_I;
            cx  = CX_JALR;
            fl  = 6'b000001;
        end
        BRANCH: begin
            fmt = IMM_B;
            ok  = (f3 != 3'b010) && (f3 != 3'b011);
            fl  = {(f3 == 3'b110) || (f3 == 3'b111), 5'b00000};
            case (f3)
                3'b000:         cx = CX_BEQ;
                3'b001:         cx = CX_BNE;
                3'b100, 3'b110: cx = CX_BLT;
                default:        cx = CX_BGE;
            endcase
        end
        LOAD: begin
            fmt = IMM_I;
            ok  = (f3 != 3'b111);
            ls  = sz;
            fl  = {f3 >= 3'd4, 5'b00101};
        end
        STORE: begin
            fmt = IMM_S;
            ok  = (f3 < 3'd4);
            ls  = sz;
            fl  = 6'b000010;
        end
        OP_IMM, OP_IMM_32, OP, OP_32: begin
            reg_form  = (w[6:0] == OP) || (w[6:0] == OP_32);
            word_form = (w[6:0] == OP_IMM_32) || (w[6:0] == OP_32);
            fmt       = reg_form ? IMM_NONE : IMM_I;
            fl        = {f3 == 3'b011, word_form, !reg_form, 3'b001};
            case (f3)
                3'b000:         alu = (reg_form && f7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                3'b001:         alu = ALU_SLL;
                3'b010, 3'b011: alu = ALU_SLT;
                3'b100:         alu = ALU_XOR;
                3'b101:         alu = (f7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
                3'b110:         alu = ALU_OR;
                default:        alu = ALU_AND;
            endcase
            // funct7 is only free for the non-shift immediate forms.
            if (reg_form || f3 == 3'b001 || f3 == 3'b101) begin
                ok = (f7 == 7'b0000000) ||
                     (f7 == 7'b0100000 && (f3 == 3'b101 || f3 == 3'b000));
            end
            if (word_form && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) begin
                ok = 1'b0;
            end
        end
        default: begin
            ok = 1'b0;
        end
    endcase

    if (!ok) begin
        alu = ALU_NONE;
        cx  = CX_NONE;
        ls  = LS_NONE;
        fl  = 6'b000000;
        fmt = IMM_NONE;
    end

    case (fmt)
        IMM_I:   s = $signed(w[31:20]);
        IMM_S:   s = $signed({w[31:25], w[11:7]});
        IMM_B:   s = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
        IMM_U:   s = $signed({w[31:12], 12'h000});
        IMM_J:   s = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
        default: s = '0;
    endcase
    im = s;
endfunction

// random instruction of one test group, with the remaining fields random.
function automatic logic [31:0] make_inst(input int unsigned grp, output string name);
    logic [31:0] w;
    int unsigned k;

    w = $random(seed);
    k = $unsigned($random(seed)) % 4;
    case (grp)
        0: begin
            name   = "alu_decode";
            w[6:0] = (k == 0) ? OP : (k == 1) ? OP_IMM : (k == 2) ? OP_IMM_32 : OP_32;
        end
        1: begin
            name   = "branch_jump";
            w[6:0] = (k == 3) ? JALR : (k == 2) ? JAL : BRANCH;
        end
        2: begin
            name   = "load_store";
            w[6:0] = k[0] ? STORE : LOAD;
        end
        default: begin
            // half of this group stays a fully random word.
            name = "upper_and_illegal";
            if (k < 2) begin
                w[6:0] = k[0] ? AUIPC : LUI;
            end
        end
    endcase

    // funct7 comes mostly from the defined set so shifts and SUB show up.
    if (grp < 3) begin
        k = $unsigned($random(seed)) % 4;
        if (k < 2) begin
            w[31:25] = 7'b0000000;
        end else if (k == 2) begin
            w[31:25] = 7'b0100000;
        end
    end
    return w;
endfunction

`endif

/* tb/tb_rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_decoder_settings.svh"

module tb_rv_decoder
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 2000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS + 20) * CLK_PERIOD;

    logic                          clock;
    logic                          rst_n;
    logic                          inst_valid;
    logic [`RV_ILEN-1:0]           inst;
    logic [`RV_PC_WIDTH-1:0]       pc;
    logic                          dec_valid;
    logic [`RV_PC_WIDTH-1:0]       dec_pc;
    logic [`RV_ILEN-1:0]           dec_inst;
    logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
    logic [`RV_REG_ADDR_WIDTH-1:0] rs2;
    logic [`RV_REG_ADDR_WIDTH-1:0] rd;
    logic [`RV_XLEN-1:0]           imm;
    alu_op_e                       alu_op;
    cx_op_e                        cx_op;
    ls_size_e                      ls_size;
    logic                          is_unsigned;
    logic                          is_word;
    logic                          is_imm;
    logic                          is_load;
    logic                          is_store;
    logic                          need_to_wb;

    integer seed;
    int     errors = 0;
    int     checks = 0;

    // exp_* is set with each issued word, chk_* is what the DUT shows now.
    logic                    exp_valid;
    string                   exp_name;
    logic [`RV_ILEN-1:0]     exp_inst;
    logic [`RV_PC_WIDTH-1:0] exp_pc;
    alu_op_e                 exp_alu;
    cx_op_e                  exp_cx;
    ls_size_e                exp_ls;
    logic [`RV_XLEN-1:0]     exp_imm;
    logic [5:0]              exp_flags;
    logic                    chk_valid;
    string                   chk_name;
    logic [`RV_ILEN-1:0]     chk_inst;
    logic [`RV_PC_WIDTH-1:0] chk_pc;
    alu_op_e                 chk_alu;
    cx_op_e                  chk_cx;
    ls_size_e                chk_ls;
    logic [`RV_XLEN-1:0]     chk_imm;
    logic [5:0]              chk_flags;

    `include "rv_decoder_ref.svh"

    rv_decoder dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .cx_op       (cx_op),
        .ls_size     (ls_size),
        .is_unsigned (is_unsigned),
        .is_word     (is_word),
        .is_imm      (is_imm),
        .is_load     (is_load),
        .is_store    (is_store),
        .need_to_wb  (need_to_wb)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic issue(input logic valid, input logic [31:0] word, input string name);
        logic [63:0] pc_bits;

        pc_bits    = {$random(seed), $random(seed)};
        inst_valid = valid;
        inst       = word;
        pc         = pc_bits[`RV_PC_WIDTH-1:0];
        exp_valid  = valid;
        exp_name   = name;
        exp_inst   = word;
        exp_pc     = pc_bits[`RV_PC_WIDTH-1:0];
        ref_decode(word, exp_alu, exp_cx, exp_ls, exp_imm, exp_flags);
    endtask

    task automatic check_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", chk_name, field,
                     expected, actual);
        end
    endtask

    // ########################################################################
    // stimulus
    // ########################################################################

    initial begin
        int unsigned pick;
        logic [31:0] word;
        string       name;

        seed  = 32'h371091eb;
        clock = 1'b0;
        rst_n = 1'b0;
        // a live instruction during reset shows that reset alone clears the outputs.
        word  = make_inst(0, name);
        issue(1'b1, word, "reset");
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        issue(1'b0, $random(seed), "reset");

        for (int n = 0; n < NUM_TESTS; n++) begin
            @(negedge clock);
            pick = $unsigned($random(seed)) % 5;
            if (pick == 0) begin
                issue(1'b0, $random(seed), "valid_gap");
            end else begin
                word = make_inst($unsigned($random(seed)) % 4, name);
                issue(1'b1, word, name);
            end
        end
        @(negedge clock);
        issue(1'b0, '0, "valid_gap");
        @(posedge clock);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // ########################################################################
    // comparison
    // ########################################################################

    // the pc, word and register fields only follow a valid instruction.
    always @(posedge clock) begin
        chk_name  = exp_name;
        chk_valid = rst_n && exp_valid;
        chk_alu   = chk_valid ? exp_alu : ALU_NONE;
        chk_cx    = chk_valid ? exp_cx : CX_NONE;
        chk_ls    = chk_valid ? exp_ls : LS_NONE;
        chk_imm   = chk_valid ? exp_imm : '0;
        chk_flags = chk_valid ? exp_flags : 6'b000000;
        if (exp_valid) begin
            chk_pc   = exp_pc;
            chk_inst = exp_inst;
        end
    end

    always @(negedge clock) begin
        check_field("dec_valid", chk_valid, dec_valid);
        check_field("alu_op", chk_alu, alu_op);
        check_field("cx_op", chk_cx, cx_op);
        check_field("ls_size", chk_ls, ls_size);
        check_field("imm", chk_imm, imm);
        check_field("flags", chk_flags,
                    {is_unsigned, is_word, is_imm, is_load, is_store, need_to_wb});
        if (chk_valid) begin
            check_field("dec_pc", chk_pc, dec_pc);
            check_field("dec_inst", chk_inst, dec_inst);
            check_field("rs1", chk_inst[19:15], rs1);
            check_field("rs2", chk_inst[24:20], rs2);
            check_field("rd", chk_inst[11:7], rd);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_decoder_settings.svh"

module rv_decoder
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [`RV_ILEN-1:0]           inst,
    input  logic [`RV_PC_WIDTH-1:0]       pc,
    output logic                          dec_valid,
    output logic [`RV_PC_WIDTH-1:0]       dec_pc,
    output logic [`RV_ILEN-1:0]           dec_inst,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rs1,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rs2,
    output logic [`RV_REG_ADDR_WIDTH-1:0] rd,
    output logic [`RV_XLEN-1:0]           imm,
    output alu_op_e                       alu_op,
    output cx_op_e                        cx_op,
    output ls_size_e                      ls_size,
    output logic                          is_unsigned,
    output logic                          is_word,
    output logic                          is_imm,
    output logic                          is_load,
    output logic                          is_store,
    output logic                          need_to_wb
);

    imm_fmt_e            nxt_imm_fmt;
    logic [`RV_XLEN-1:0] nxt_imm;
    alu_op_e             nxt_alu_op;
    cx_op_e              nxt_cx_op;
    ls_size_e            nxt_ls_size;
    logic                nxt_is_unsigned;
    logic                nxt_is_word;
    logic                nxt_is_imm;
    logic                nxt_is_load;
    logic                nxt_is_store;
    logic                nxt_need_to_wb;

    rv_op_decode u_op_decode (
        .inst        (inst),
        .imm_fmt     (nxt_imm_fmt),
        .alu_op      (nxt_alu_op),
        .cx_op       (nxt_cx_op),
        .ls_size     (nxt_ls_size),
        .is_unsigned (nxt_is_unsigned),
        .is_word     (nxt_is_word),
        .is_imm      (nxt_is_imm),
        .is_load     (nxt_is_load),
        .is_store    (nxt_is_store),
        .need_to_wb  (nxt_need_to_wb)
    );

    rv_imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (nxt_imm_fmt),
        .imm     (nxt_imm)
    );

    // ########################################################################
    // output stage. controls fall back to NONE in any cycle without an
    // instruction, while the register fields and pc keep the last one.
    // ########################################################################

    always_ff @(posedge clock) begin
        if (!rst_n || !inst_valid) begin
            dec_valid   <= 1'b0;
            imm         <= '0;
            alu_op      <= ALU_NONE;
            cx_op       <= CX_NONE;
            ls_size     <= LS_NONE;
            is_unsigned <= 1'b0;
            is_word     <= 1'b0;
            is_imm      <= 1'b0;
            is_load     <= 1'b0;
            is_store    <= 1'b0;
            need_to_wb  <= 1'b0;
        end else begin
            dec_valid   <= 1'b1;
            imm         <= nxt_imm;
            alu_op      <= nxt_alu_op;
            cx_op       <= nxt_cx_op;
            ls_size     <= nxt_ls_size;
            is_unsigned <= nxt_is_unsigned;
            is_word     <= nxt_is_word;
            is_imm      <= nxt_is_imm;
            is_load     <= nxt_is_load;
            is_store    <= nxt_is_store;
            need_to_wb  <= nxt_need_to_wb;
        end
    end

    always_ff @(posedge clock) begin
        if (inst_valid) begin
            dec_pc   <= pc;
            dec_inst <= inst;
            rs1      <= inst[19:15];
            rs2      <= inst[24:20];
            rd       <= inst[11:7];
        end
    end

    // ########################################################################
    // checks on the registered decode.
    // ########################################################################

    // a memory access is either a load or a store, never both.
    assert property (@(posedge clock) disable iff (!rst_n) !(is_load && is_store));

    assert property (@(posedge clock) disable iff (!rst_n) !dec_valid |-> !need_to_wb);

    // pc-relative targets of branches and JAL are always half-word aligned.
    assert property (@(posedge clock) disable iff (!rst_n)
        (cx_op inside {CX_JAL, CX_BEQ, CX_BNE, CX_BLT, CX_BGE}) |-> (imm[0] == 1'b0));

endmodule

/* verilog/rv_op_decode.sv */
`timescale 1ns/1ps
`include "rv_decoder_settings.svh"

module rv_op_decode
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic [`RV_ILEN-1:0] inst,
    output imm_fmt_e            imm_fmt,
    output alu_op_e             alu_op,
    output cx_op_e              cx_op,
    output ls_size_e            ls_size,
    output logic                is_unsigned,
    output logic                is_word,
    output logic                is_imm,
    output logic                is_load,
    output logic                is_store,
    output logic                need_to_wb
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ########################################################################
    // per-group decode. legal drops when funct3 or funct7 is not defined.
    // ########################################################################

    always_comb begin
        legal       = 1'b1;
        imm_fmt     = IMM_NONE;
        alu_op      = ALU_NONE;
        cx_op       = CX_NONE;
        ls_size     = LS_NONE;
        is_unsigned = 1'b0;
        is_word     = 1'b0;
        is_imm      = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        need_to_wb  = 1'b0;

        case (opcode)
            LUI, AUIPC: begin
                imm_fmt    = IMM_U;
                alu_op     = (opcode == LUI) ? ALU_LUI : ALU_AUIPC;
                need_to_wb = 1'b1;
            end
            JAL: begin
                imm_fmt    = IMM_J;
                cx_op      = CX_JAL;
                need_to_wb = 1'b1;
            end
            JALR: begin
                imm_fmt    = IMM_I;
                cx_op      = CX_JALR;
                need_to_wb = 1'b1;
            end
            BRANCH: begin
                imm_fmt     = IMM_B;
                is_unsigned = funct3[1];
                case (funct3)
                    3'b000:         cx_op = CX_BEQ;
                    3'b001:         cx_op = CX_BNE;
                    3'b100, 3'b110: cx_op = CX_BLT;
                    3'b101, 3'b111: cx_op = CX_BGE;
                    default:        legal = 1'b0;
                endcase
            end
            LOAD: begin
                imm_fmt     = IMM_I;
                is_load     = 1'b1;
                need_to_wb  = 1'b1;
                is_unsigned = funct3[2];
                case (funct3)
                    3'b000, 3'b100: ls_size = LS_B;
                    3'b001, 3'b101: ls_size = LS_H;
                    3'b010, 3'b110: ls_size = LS_W;
                    3'b011:         ls_size = LS_D;
                    default:        legal   = 1'b0;
                endcase
            end
            STORE: begin
                imm_fmt  = IMM_S;
                is_store = 1'b1;
                case (funct3)
                    3'b000:  ls_size = LS_B;
                    3'b001:  ls_size = LS_H;
                    3'b010:  ls_size = LS_W;
                    3'b011:  ls_size = LS_D;
                    default: legal   = 1'b0;
                endcase
            end
            OP_IMM, OP_IMM_32: begin
                imm_fmt    = IMM_I;
                is_imm     = 1'b1;
                need_to_wb = 1'b1;
                is_word    = (opcode == OP_IMM_32);
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: begin
                        alu_op      = ALU_SLT;
                        is_unsigned = 1'b1;
                    end
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        if (funct7 == F7_BASE) alu_op = ALU_SLL;
                        else                   legal  = 1'b0;
                    end
                    default: begin
                        if (funct7 == F7_BASE)     alu_op = ALU_SRL;
                        else if (funct7 == F7_ALT) alu_op = ALU_SRA;
                        else                       legal  = 1'b0;
                    end
                endcase
            end
            OP, OP_32: begin
                need_to_wb = 1'b1;
                is_word    = (opcode == OP_32);
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: alu_op = ALU_SUB;
                    {F7_BASE, 3'b001}: alu_op = ALU_SLL;
                    {F7_BASE, 3'b010}: alu_op = ALU_SLT;
                    {F7_BASE, 3'b011}: begin
                        alu_op      = ALU_SLT;
                        is_unsigned = 1'b1;
                    end
                    {F7_BASE, 3'b100}: alu_op = ALU_XOR;
                    {F7_BASE, 3'b101}: alu_op = ALU_SRL;
                    {F7_ALT,  3'b101}: alu_op = ALU_SRA;
                    {F7_BASE, 3'b110}: alu_op = ALU_OR;
                    {F7_BASE, 3'b111}: alu_op = ALU_AND;
                    default:           legal  = 1'b0;
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // the W forms only have add, sub and the three shifts.
        if (is_word && !(alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA})) begin
            legal = 1'b0;
        end

        if (!legal) begin
            imm_fmt     = IMM_NONE;
            alu_op      = ALU_NONE;
            cx_op       = CX_NONE;
            ls_size     = LS_NONE;
            is_unsigned = 1'b0;
            is_word     = 1'b0;
            is_imm      = 1'b0;
            is_load     = 1'b0;
            is_store    = 1'b0;
            need_to_wb  = 1'b0;
        end
    end

endmodule

/* verilog/rv_imm_gen.sv */
`timescale 1ns/1ps
`include "rv_decoder_settings.svh"

module rv_imm_gen
    import rv_isa_pkg::*;
(
    input  logic [`RV_ILEN-1:0] inst,
    input  imm_fmt_e            imm_fmt,
    output logic [`RV_XLEN-1:0] imm
);

    // every format keeps its sign in inst[31].
    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(`RV_XLEN-12){sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{(`RV_XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{(`RV_XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {{(`RV_XLEN-32){sign}}, inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(`RV_XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* verilog/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // ########################################################################
    // control fields handed to the execute units.
    // ########################################################################

    typedef enum logic [3:0] {
        ALU_NONE  = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_SLL   = 4'd3,
        ALU_SLT   = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11
    } alu_op_e;

    // unsigned branch compares reuse BLT and BGE with is_unsigned set.
    typedef enum logic [2:0] {
        CX_NONE = 3'd0,
        CX_JAL  = 3'd1,
        CX_JALR = 3'd2,
        CX_BEQ  = 3'd3,
        CX_BNE  = 3'd4,
        CX_BLT  = 3'd5,
        CX_BGE  = 3'd6
    } cx_op_e;

    typedef enum logic [2:0] {
        LS_NONE = 3'd0,
        LS_B    = 3'd1,
        LS_H    = 3'd2,
        LS_W    = 3'd3,
        LS_D    = 3'd4
    } ls_size_e;

endpackage

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ########################################################################
    // major opcodes of the RV64I base set, inst[6:0].
    // ########################################################################

    typedef enum logic [6:0] {
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP        = 7'b0110011,
        OP_IMM_32 = 7'b0011011,
        OP_32     = 7'b0111011
    } opcode_e;

    // immediate layouts as named in the ISA manual.
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

endpackage

/* verilog/rv_decoder_settings.svh */
`ifndef RV_DECODER_SETTINGS_SVH
`define RV_DECODER_SETTINGS_SVH

// data path and immediate width.
`define RV_XLEN 64

// instruction word width.
`define RV_ILEN 32

`define RV_PC_WIDTH 48

`define RV_REG_ADDR_WIDTH 5

`endif
